//--- Bender.yml
package:
  name: tile_read

sources:
  - files:
      - tile_read_cfg_pkg.sv
      - tile_read_types_pkg.sv
      - rdyack_fifo.sv
      - tile_addr_gen.sv
      - tile_buffer.sv
      - tile_fill_writer.sv
      - tile_reader.sv
      - tile_read_pipeline.sv
  - target: test
    files:
      - tile_read_properties.sv
      - tb_tile_read_pipeline.sv

//--- rdyack_fifo.sv
// small rdy/ack FIFO for any packed payload
// circular buffer with read/write pointers and an occupancy count
// push and pop may happen in the same cycle
`default_nettype none

module rdyack_fifo #(
	parameter type payload_t = logic [7:0],
	parameter int DEPTH = 2
) (
	input  wire logic     i_clk,
	input  wire logic     i_rst,
	input  wire logic     i_src_rdy,
	output logic          o_src_ack,
	input  wire payload_t i_src_data,
	output logic          o_dst_rdy,
	input  wire logic     i_dst_ack,
	output payload_t      o_dst_data
);

	localparam int PTR_BW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_BW = $clog2(DEPTH + 1);

	payload_t          mem [DEPTH];
	logic [PTR_BW-1:0] wr_ptr;
	logic [PTR_BW-1:0] rd_ptr;
	logic [CNT_BW-1:0] count;
	logic              push;
	logic              pop;

	function automatic logic [PTR_BW-1:0] next_ptr(input logic [PTR_BW-1:0] ptr);
		return (ptr == PTR_BW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	// ack only an offered item, and only while there is room
	assign o_src_ack  = i_src_rdy && (count != CNT_BW'(DEPTH));
	assign o_dst_rdy  = (count != '0);
	assign o_dst_data = mem[rd_ptr];

	assign push = i_src_rdy && o_src_ack;
	assign pop  = o_dst_rdy && i_dst_ack;

	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (pop) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// storage
	always_ff @(posedge i_clk) begin
		if (push) begin
			mem[wr_ptr] <= i_src_data;
		end
	end

endmodule

`default_nettype wire

//--- tb_tile_read_pipeline.sv
// testbench for the tile read pipeline
// trace-driven tile requests, in-order DRAM model with LFSR stalls,
// output row checks and an output stall phase
`default_nettype none

module tb_tile_read_pipeline
	import tile_read_cfg_pkg::*;
	import tile_read_types_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int TIMEOUT = 2000;
	// tiles at the end of the trace that run with the output held off
	localparam int N_STALL_TILES = 4;

	logic                i_clk = 1'b0;
	logic                i_rst;
	logic                i_req_rdy;
	tile_req_t           i_req;
	logic                o_req_ack;
	logic                o_dram_ra_rdy;
	logic [GADDR_BW-1:0] o_dram_ra;
	logic                i_dram_ra_ack;
	logic                i_dram_rd_rdy;
	row_data_t           i_dram_rd;
	logic                o_dram_rd_ack;
	logic                o_row_rdy;
	row_out_t            o_row;
	logic                i_row_ack;

	tile_req_t           req_q[$];
	logic [GADDR_BW-1:0] exp_addr_q[$];
	logic                exp_first_q[$];
	row_out_t            exp_row_q[$];
	logic [GADDR_BW-1:0] dram_q[$];
	logic [31:0]         lfsr_state = 32'h2dbf;
	logic                stim_on = 1'b0;
	logic                row_stall = 1'b0;
	logic                ra_xfer = 1'b0;
	logic                rd_xfer = 1'b0;
	int                  addrs_seen = 0;
	int                  rows_seen = 0;
	int                  tiles_started = 0;
	int                  total_rows = 0;

	tile_read_pipeline dut (
		.i_clk(i_clk), .i_rst(i_rst),
		.i_req_rdy(i_req_rdy), .i_req(i_req), .o_req_ack(o_req_ack),
		.o_dram_ra_rdy(o_dram_ra_rdy), .o_dram_ra(o_dram_ra), .i_dram_ra_ack(i_dram_ra_ack),
		.i_dram_rd_rdy(i_dram_rd_rdy), .i_dram_rd(i_dram_rd), .o_dram_rd_ack(o_dram_rd_ack),
		.o_row_rdy(o_row_rdy), .o_row(o_row), .i_row_ack(i_row_ack)
	);

	bind tile_read_pipeline tile_read_properties u_props (
		.i_clk(i_clk), .i_rst(i_rst),
		.i_req_rdy(i_req_rdy), .i_req(i_req), .i_req_ack(o_req_ack),
		.i_ra_rdy(o_dram_ra_rdy), .i_ra(o_dram_ra), .i_ra_ack(i_dram_ra_ack),
		.i_rd_rdy(i_dram_rd_rdy), .i_rd(i_dram_rd), .i_rd_ack(o_dram_rd_ack),
		.i_row_rdy(o_row_rdy), .i_row(o_row), .i_row_ack(i_row_ack),
		.i_slot_cnt(u_addr_gen.slot_cnt)
	);

	always #5 i_clk = ~i_clk;

	// ==================================================
	// helpers
	// ==================================================
	// fibonacci LFSR with taps x^32 + x^22 + x^2 + x + 1
	function automatic logic rand_bit();
		logic fb;
		fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
		lfsr_state = {lfsr_state[30:0], fb};
		return fb;
	endfunction

	// word k holds the address in the upper half and k in the lower half
	function automatic row_data_t dram_row(input logic [GADDR_BW-1:0] addr);
		row_data_t row;
		for (int k = 0; k < ROW_WORDS; k++) begin
			row.words[k] = {addr, 16'(k)};
		end
		return row;
	endfunction

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("test failed");
		$fatal(1, "%s", what);
	endtask

	task automatic check_value(input string name, input logic [159:0] expected,
			input logic [159:0] actual);
		if (expected !== actual) begin
			$display("FAILED %s: expected %0h, actual %0h", name, expected, actual);
			$display("test failed");
			$fatal(1, "%s mismatch", name);
		end
	endtask

	// reads one tile per line and builds the expected rows and addresses
	task automatic load_trace();
		int        fd;
		int        n;
		int        base;
		int        rows;
		int        stride;
		int        tag;
		int        a[4];
		string     line;
		tile_req_t req;
		row_out_t  exp;
		fd = $fopen("tile_read_trace.txt", "r");
		if (fd == 0) begin
			report_failure("could not open the trace file tile_read_trace.txt");
		end
		while (!$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			if (n > 0 && line.getc(0) != "#") begin
				n = $sscanf(line, "%h %h %h %h %h %h %h %h",
					base, rows, stride, tag, a[0], a[1], a[2], a[3]);
				if (n == 8) begin
					if (rows < 1 || rows > MAX_ROWS) begin
						report_failure("trace line has a row count out of range");
					end
					req.base   = base[GADDR_BW-1:0];
					req.rows   = rows[ROWCNT_BW-1:0];
					req.stride = stride[GADDR_BW-1:0];
					req.tag    = tag[TAG_BW-1:0];
					req_q.push_back(req);
					for (int r = 0; r < rows; r++) begin
						check_value("trace address", GADDR_BW'(req.base + r * req.stride),
							a[r][GADDR_BW-1:0]);
						exp_addr_q.push_back(a[r][GADDR_BW-1:0]);
						exp_first_q.push_back(r == 0);
						exp.row  = dram_row(a[r][GADDR_BW-1:0]);
						exp.tag  = req.tag;
						exp.last = (r == rows - 1);
						exp_row_q.push_back(exp);
						total_rows++;
					end
				end
			end
		end
		$fclose(fd);
		if (req_q.size() <= N_STALL_TILES + N_SLOTS) begin
			report_failure("trace file holds too few tile requests");
		end
	endtask

	task automatic check_idle_outputs();
		repeat (4) begin
			@(negedge i_clk);
			check_value("request ack after reset", 1'b0, o_req_ack);
			check_value("DRAM address rdy after reset", 1'b0, o_dram_ra_rdy);
			check_value("row rdy after reset", 1'b0, o_row_rdy);
		end
	endtask

	// entered just after a rising edge and left just after the transfer edge
	task automatic send_request(input tile_req_t req);
		int waited;
		i_req_rdy = 1'b1;
		i_req     = req;
		waited    = 0;
		@(negedge i_clk);
		while (!o_req_ack) begin
			waited++;
			if (waited > TIMEOUT) begin
				report_failure("a tile request was never acknowledged");
			end
			@(negedge i_clk);
		end
		@(posedge i_clk);
		#1;
	endtask

	task automatic wait_for_rows(input int target);
		int waited;
		waited = 0;
		while (rows_seen < target) begin
			waited++;
			if (waited > TIMEOUT) begin
				report_failure($sformatf("only %0d of %0d output rows arrived",
					rows_seen, target));
			end
			@(posedge i_clk);
		end
	endtask

	task automatic wait_for_addresses(input int target);
		int waited;
		waited = 0;
		while (addrs_seen < target) begin
			waited++;
			if (waited > TIMEOUT) begin
				report_failure($sformatf("only %0d of %0d DRAM addresses were issued",
					addrs_seen, target));
			end
			@(posedge i_clk);
		end
	endtask

	// ==================================================
	// DRAM model and output side
	// ==================================================
	// sampled mid-cycle where all handshakes are settled
	always @(negedge i_clk) begin
		if (!i_rst) begin
			ra_xfer = 1'b0;
			rd_xfer = 1'b0;
		end else begin
			ra_xfer = o_dram_ra_rdy && i_dram_ra_ack;
			rd_xfer = i_dram_rd_rdy && o_dram_rd_ack;
			if (rd_xfer) begin
				void'(dram_q.pop_front());
			end
			if (ra_xfer) begin
				if (exp_addr_q.size() == 0) begin
					report_failure("a DRAM address was issued beyond the trace");
				end
				check_value($sformatf("dram address %0d", addrs_seen), exp_addr_q[0], o_dram_ra);
				if (exp_first_q[0]) begin
					tiles_started++;
				end
				void'(exp_addr_q.pop_front());
				void'(exp_first_q.pop_front());
				dram_q.push_back(o_dram_ra);
				addrs_seen++;
			end
			if (o_row_rdy && i_row_ack) begin
				if (exp_row_q.size() == 0) begin
					report_failure("an output row arrived when none was expected");
				end
				check_value($sformatf("row %0d data", rows_seen), exp_row_q[0].row, o_row.row);
				check_value($sformatf("row %0d tag", rows_seen), exp_row_q[0].tag, o_row.tag);
				check_value($sformatf("row %0d last", rows_seen), exp_row_q[0].last, o_row.last);
				void'(exp_row_q.pop_front());
				rows_seen++;
			end
		end
	end

	always @(posedge i_clk) begin
		#1;
		if (!stim_on) begin
			i_dram_ra_ack = 1'b0;
			i_dram_rd_rdy = 1'b0;
			i_row_ack     = 1'b0;
		end else begin
			i_dram_ra_ack = rand_bit();
			// a raised rdy stays up until its transfer
			if (!i_dram_rd_rdy || rd_xfer) begin
				if (dram_q.size() != 0 && rand_bit()) begin
					i_dram_rd_rdy = 1'b1;
					i_dram_rd     = dram_row(dram_q[0]);
				end else begin
					i_dram_rd_rdy = 1'b0;
				end
			end
			i_row_ack = row_stall ? 1'b0 : rand_bit();
		end
	end

	always @(posedge i_clk) begin
		if (dut.u_props.fail_count != 0) begin
			report_failure("a protocol assertion on the DUT ports failed");
		end
	end

	// ==================================================
	// main sequence
	// ==================================================
	initial begin
		int n_first;
		int first_rows;
		int stall_addrs;
		int addrs_before;
		int tiles_before;
		int rows_before;
		i_rst         = 1'b0;
		i_req_rdy     = 1'b0;
		i_req         = '0;
		i_dram_ra_ack = 1'b0;
		i_dram_rd_rdy = 1'b0;
		i_dram_rd     = '0;
		i_row_ack     = 1'b0;
		load_trace();
		n_first     = req_q.size() - N_STALL_TILES;
		first_rows  = 0;
		stall_addrs = 0;
		for (int i = 0; i < n_first; i++) begin
			first_rows += req_q[i].rows;
		end
		for (int i = 0; i < N_SLOTS; i++) begin
			stall_addrs += req_q[n_first + i].rows;
		end

		repeat (8) @(posedge i_clk);
		#1;
		i_rst = 1'b1;
		check_idle_outputs();
		stim_on = 1'b1;
		@(posedge i_clk);
		#1;

		// random stalls on all three acknowledges
		for (int i = 0; i < n_first; i++) begin
			send_request(req_q[i]);
		end
		i_req_rdy = 1'b0;
		wait_for_rows(first_rows);

		// with the output held off only N_SLOTS tiles may be addressed
		@(negedge i_clk);
		row_stall    = 1'b1;
		addrs_before = addrs_seen;
		tiles_before = tiles_started;
		rows_before  = rows_seen;
		@(posedge i_clk);
		#1;
		for (int i = n_first; i < req_q.size(); i++) begin
			send_request(req_q[i]);
		end
		i_req_rdy = 1'b0;
		wait_for_addresses(addrs_before + stall_addrs);
		// long enough for a further tile to start if a slot were freed early
		repeat (50) @(posedge i_clk);
		@(negedge i_clk);
		check_value("tiles addressed under output stall", N_SLOTS, tiles_started - tiles_before);
		check_value("addresses under output stall", stall_addrs, addrs_seen - addrs_before);
		// first row of the stalled tiles waits at the output
		check_value("row rdy under output stall", 1'b1, o_row_rdy);
		check_value("row held under output stall", exp_row_q[0], o_row);
		row_stall = 1'b0;
		wait_for_rows(total_rows);

		repeat (20) @(posedge i_clk);
		check_value("addresses left", 0, exp_addr_q.size());
		check_value("DRAM reads left", 0, dram_q.size());
		if (dut.u_props.fail_count != 0) begin
			$display("%0d protocol assertions failed", dut.u_props.fail_count);
			$display("test failed");
			$fatal(1, "protocol assertion failure");
		end else begin
			$display("test passed");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- tile_addr_gen.sv
// input side of the tile read pipeline
// slot allocation with occupancy count and round-robin pointer
// one DRAM read address per row, base + r * stride
`default_nettype none

module tile_addr_gen
	import tile_read_cfg_pkg::*;
	import tile_read_types_pkg::*;
(
	input  wire logic          i_clk,
	input  wire logic          i_rst,
	input  wire logic          i_req_rdy,
	output logic               o_req_ack,
	input  wire tile_req_t     i_req,
	output logic               o_cmd_rdy,
	input  wire logic          i_cmd_ack,
	output slot_cmd_t          o_cmd,
	output logic               o_ra_rdy,
	input  wire logic          i_ra_ack,
	output logic [GADDR_BW-1:0] o_ra,
	input  wire logic          i_slot_free
);

	logic [OCC_BW-1:0]    slot_cnt;
	logic [SLOT_BW-1:0]   alloc_ptr;
	logic [ROWCNT_BW-1:0] rows_left;
	logic                 busy;
	logic [GADDR_BW-1:0]  addr;
	logic [GADDR_BW-1:0]  stride;
	logic                 can_alloc;
	logic                 ra_xfer;

	// ==================================================
	// request acceptance
	// ==================================================
	assign can_alloc = !busy && (slot_cnt != OCC_BW'(N_SLOTS));
	assign o_cmd_rdy = i_req_rdy && can_alloc;
	// command push and request pop in the same cycle
	assign o_req_ack = o_cmd_rdy && i_cmd_ack;

	assign o_cmd.slot = alloc_ptr;
	assign o_cmd.rows = i_req.rows;
	assign o_cmd.tag  = i_req.tag;

	assign o_ra_rdy = busy;
	assign o_ra     = addr;
	assign ra_xfer  = o_ra_rdy && i_ra_ack;

	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			slot_cnt  <= '0;
			alloc_ptr <= '0;
			rows_left <= '0;
			busy      <= 1'b0;
		end else begin
			case ({o_req_ack, i_slot_free})
				2'b10: slot_cnt <= slot_cnt + 1'b1;
				2'b01: slot_cnt <= slot_cnt - 1'b1;
				default: slot_cnt <= slot_cnt;
			endcase
			if (o_req_ack) begin
				// slots retire in allocation order
				alloc_ptr <= (alloc_ptr == SLOT_BW'(N_SLOTS - 1)) ? '0 : alloc_ptr + 1'b1;
				rows_left <= i_req.rows;
				busy      <= 1'b1;
			end else if (ra_xfer) begin
				rows_left <= rows_left - 1'b1;
				if (rows_left == ROWCNT_BW'(1)) begin
					busy <= 1'b0;
				end
			end
		end
	end

	// address accumulator
	always_ff @(posedge i_clk) begin
		if (o_req_ack) begin
			addr   <= i_req.base;
			stride <= i_req.stride;
		end else if (ra_xfer) begin
			addr <= addr + stride;
		end
	end

endmodule

`default_nettype wire

//--- tile_buffer.sv
// slot-organized local row buffer
// one write port, one read port with registered output
// address is {slot, row index}
`default_nettype none

module tile_buffer
	import tile_read_cfg_pkg::*;
	import tile_read_types_pkg::*;
(
	input  wire logic              i_clk,
	input  wire logic              i_wr_en,
	input  wire logic [BUF_AW-1:0] i_wr_addr,
	input  wire row_data_t         i_wr_row,
	input  wire logic              i_rd_en,
	input  wire logic [BUF_AW-1:0] i_rd_addr,
	output row_data_t              o_rd_row
);

	row_data_t mem [BUF_ROWS];

	always_ff @(posedge i_clk) begin
		if (i_wr_en) begin
			mem[i_wr_addr] <= i_wr_row;
		end
		// output holds until the next read
		if (i_rd_en) begin
			o_rd_row <= mem[i_rd_addr];
		end
	end

endmodule

`default_nettype wire

//--- tile_fill_writer.sv
// fill stage of the tile read pipeline
// writes returned DRAM rows into the allocated slot
// hands the slot command on once the tile is complete
`default_nettype none

module tile_fill_writer
	import tile_read_cfg_pkg::*;
	import tile_read_types_pkg::*;
(
	input  wire logic         i_clk,
	input  wire logic         i_rst,
	input  wire logic         i_cmd_rdy,
	output logic              o_cmd_ack,
	input  wire slot_cmd_t    i_cmd,
	input  wire logic         i_rd_rdy,
	output logic              o_rd_ack,
	input  wire row_data_t    i_rd,
	output logic              o_wr_en,
	output logic [BUF_AW-1:0] o_wr_addr,
	output row_data_t         o_wr_row,
	output logic              o_done_rdy,
	input  wire logic         i_done_ack,
	output slot_cmd_t         o_done
);

	slot_cmd_t             cmd_q;
	logic                  active;
	logic                  done_pend;
	logic [ROW_IDX_BW-1:0] row_idx;
	logic                  last_row;
	logic                  rd_xfer;

	assign o_cmd_ack = i_cmd_rdy && !active && !done_pend;
	// DRAM data only flows while a fill command is active
	assign o_rd_ack  = i_rd_rdy && active;
	assign rd_xfer   = i_rd_rdy && o_rd_ack;
	assign last_row  = (ROWCNT_BW'(row_idx) + ROWCNT_BW'(1)) == cmd_q.rows;

	assign o_wr_en   = rd_xfer;
	assign o_wr_addr = {cmd_q.slot, row_idx};
	assign o_wr_row  = i_rd;

	assign o_done_rdy = done_pend;
	assign o_done     = cmd_q;

	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			active    <= 1'b0;
			done_pend <= 1'b0;
			row_idx   <= '0;
		end else begin
			if (o_cmd_ack) begin
				active  <= 1'b1;
				row_idx <= '0;
			end else if (rd_xfer) begin
				row_idx <= row_idx + 1'b1;
				if (last_row) begin
					active    <= 1'b0;
					done_pend <= 1'b1;
				end
			end
			if (done_pend && i_done_ack) begin
				done_pend <= 1'b0;
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (o_cmd_ack) begin
			cmd_q <= i_cmd;
		end
	end

endmodule

`default_nettype wire

//--- tile_read_cfg_pkg.sv
// configuration constants for the tile read pipeline
// address, data and row geometry of the local row buffer
// derived widths and FIFO depths
`default_nettype none

package tile_read_cfg_pkg;

	// ==================================================
	// base geometry
	// ==================================================
	localparam int GADDR_BW  = 16;
	localparam int WORD_BW   = 32;
	localparam int ROW_WORDS = 4;
	localparam int MAX_ROWS  = 4;
	localparam int N_SLOTS   = 2;
	// one slot holds a full tile
	localparam int BUF_ROWS  = N_SLOTS * MAX_ROWS;
	localparam int TAG_BW    = 4;

	// ==================================================
	// derived widths
	// ==================================================
	// row count 1..MAX_ROWS
	localparam int ROWCNT_BW  = $clog2(MAX_ROWS + 1);
	localparam int ROW_IDX_BW = $clog2(MAX_ROWS);
	localparam int SLOT_BW    = $clog2(N_SLOTS);
	// occupancy 0..N_SLOTS
	localparam int OCC_BW     = $clog2(N_SLOTS + 1);
	localparam int BUF_AW     = $clog2(BUF_ROWS);

	localparam int REQ_FIFO_DEPTH = 2;
	localparam int CMD_FIFO_DEPTH = 2;

endpackage

`default_nettype wire

//--- tile_read_pipeline.f
tile_read_cfg_pkg.sv
tile_read_types_pkg.sv
rdyack_fifo.sv
tile_addr_gen.sv
tile_buffer.sv
tile_fill_writer.sv
tile_reader.sv
tile_read_pipeline.sv
tile_read_properties.sv
tb_tile_read_pipeline.sv

//--- tile_read_pipeline.sv
// top level of the tile read pipeline
// request FIFO -> address generator -> fill command FIFO -> fill writer
// fill writer -> row buffer and ready FIFO -> reader -> output rows
`default_nettype none

module tile_read_pipeline
	import tile_read_cfg_pkg::*;
	import tile_read_types_pkg::*;
(
	input  wire logic           i_clk,
	input  wire logic           i_rst,
	input  wire logic           i_req_rdy,
	input  wire tile_req_t      i_req,
	output logic                o_req_ack,
	output logic                o_dram_ra_rdy,
	output logic [GADDR_BW-1:0] o_dram_ra,
	input  wire logic           i_dram_ra_ack,
	input  wire logic           i_dram_rd_rdy,
	input  wire row_data_t      i_dram_rd,
	output logic                o_dram_rd_ack,
	output logic                o_row_rdy,
	output row_out_t            o_row,
	input  wire logic           i_row_ack
);

	// ==================================================
	// internal channels
	// ==================================================
	logic              req_rdy;
	logic              req_ack;
	tile_req_t         req;
	logic              alloc_cmd_rdy;
	logic              alloc_cmd_ack;
	slot_cmd_t         alloc_cmd;
	logic              fill_cmd_rdy;
	logic              fill_cmd_ack;
	slot_cmd_t         fill_cmd;
	logic              done_rdy;
	logic              done_ack;
	slot_cmd_t         done_cmd;
	logic              read_cmd_rdy;
	logic              read_cmd_ack;
	slot_cmd_t         read_cmd;
	logic              wr_en;
	logic [BUF_AW-1:0] wr_addr;
	row_data_t         wr_row;
	logic              rd_en;
	logic [BUF_AW-1:0] rd_addr;
	row_data_t         rd_row;
	logic              slot_free;

	rdyack_fifo #(.payload_t(tile_req_t), .DEPTH(REQ_FIFO_DEPTH)) u_req_fifo (
		.i_clk(i_clk), .i_rst(i_rst),
		.i_src_rdy(i_req_rdy), .o_src_ack(o_req_ack), .i_src_data(i_req),
		.o_dst_rdy(req_rdy), .i_dst_ack(req_ack), .o_dst_data(req)
	);

	tile_addr_gen u_addr_gen (
		.i_clk(i_clk), .i_rst(i_rst),
		.i_req_rdy(req_rdy), .o_req_ack(req_ack), .i_req(req),
		.o_cmd_rdy(alloc_cmd_rdy), .i_cmd_ack(alloc_cmd_ack), .o_cmd(alloc_cmd),
		.o_ra_rdy(o_dram_ra_rdy), .i_ra_ack(i_dram_ra_ack), .o_ra(o_dram_ra),
		.i_slot_free(slot_free)
	);

	rdyack_fifo #(.payload_t(slot_cmd_t), .DEPTH(CMD_FIFO_DEPTH)) u_cmd_fifo (
		.i_clk(i_clk), .i_rst(i_rst),
		.i_src_rdy(alloc_cmd_rdy), .o_src_ack(alloc_cmd_ack), .i_src_data(alloc_cmd),
		.o_dst_rdy(fill_cmd_rdy), .i_dst_ack(fill_cmd_ack), .o_dst_data(fill_cmd)
	);

	tile_fill_writer u_fill_writer (
		.i_clk(i_clk), .i_rst(i_rst),
		.i_cmd_rdy(fill_cmd_rdy), .o_cmd_ack(fill_cmd_ack), .i_cmd(fill_cmd),
		.i_rd_rdy(i_dram_rd_rdy), .o_rd_ack(o_dram_rd_ack), .i_rd(i_dram_rd),
		.o_wr_en(wr_en), .o_wr_addr(wr_addr), .o_wr_row(wr_row),
		.o_done_rdy(done_rdy), .i_done_ack(done_ack), .o_done(done_cmd)
	);

	tile_buffer u_buffer (
		.i_clk(i_clk),
		.i_wr_en(wr_en), .i_wr_addr(wr_addr), .i_wr_row(wr_row),
		.i_rd_en(rd_en), .i_rd_addr(rd_addr), .o_rd_row(rd_row)
	);

	// completed slots waiting for the reader
	rdyack_fifo #(.payload_t(slot_cmd_t), .DEPTH(CMD_FIFO_DEPTH)) u_ready_fifo (
		.i_clk(i_clk), .i_rst(i_rst),
		.i_src_rdy(done_rdy), .o_src_ack(done_ack), .i_src_data(done_cmd),
		.o_dst_rdy(read_cmd_rdy), .i_dst_ack(read_cmd_ack), .o_dst_data(read_cmd)
	);

	tile_reader u_reader (
		.i_clk(i_clk), .i_rst(i_rst),
		.i_cmd_rdy(read_cmd_rdy), .o_cmd_ack(read_cmd_ack), .i_cmd(read_cmd),
		.o_rd_en(rd_en), .o_rd_addr(rd_addr), .i_rd_row(rd_row),
		.o_row_rdy(o_row_rdy), .i_row_ack(i_row_ack), .o_row(o_row),
		.o_slot_free(slot_free)
	);

endmodule

`default_nettype wire

//--- tile_read_properties.sv
// protocol assertions for the tile read pipeline
// rdy held with stable data until ack on every channel
// slot occupancy bound, idle outputs while in reset
`default_nettype none

module tile_read_properties
	import tile_read_cfg_pkg::*;
	import tile_read_types_pkg::*;
(
	input wire logic                i_clk,
	input wire logic                i_rst,
	input wire logic                i_req_rdy,
	input wire tile_req_t           i_req,
	input wire logic                i_req_ack,
	input wire logic                i_ra_rdy,
	input wire logic [GADDR_BW-1:0] i_ra,
	input wire logic                i_ra_ack,
	input wire logic                i_rd_rdy,
	input wire row_data_t           i_rd,
	input wire logic                i_rd_ack,
	input wire logic                i_row_rdy,
	input wire row_out_t            i_row,
	input wire logic                i_row_ack,
	input wire logic [OCC_BW-1:0]   i_slot_cnt
);

	timeunit 1ns;
	timeprecision 100ps;

	int fail_count = 0;

	// ==================================================
	// rdy/ack channels
	// ==================================================
	req_held: assert property (@(posedge i_clk) disable iff (!i_rst)
		i_req_rdy && !i_req_ack |=> i_req_rdy && $stable(i_req))
		else begin
			fail_count++;
			$error("request rdy dropped or data changed before ack");
		end

	ra_held: assert property (@(posedge i_clk) disable iff (!i_rst)
		i_ra_rdy && !i_ra_ack |=> i_ra_rdy && $stable(i_ra))
		else begin
			fail_count++;
			$error("DRAM address rdy dropped or address changed before ack");
		end

	rd_held: assert property (@(posedge i_clk) disable iff (!i_rst)
		i_rd_rdy && !i_rd_ack |=> i_rd_rdy && $stable(i_rd))
		else begin
			fail_count++;
			$error("DRAM data rdy dropped or data changed before ack");
		end

	row_held: assert property (@(posedge i_clk) disable iff (!i_rst)
		i_row_rdy && !i_row_ack |=> i_row_rdy && $stable(i_row))
		else begin
			fail_count++;
			$error("output row rdy dropped or row changed before ack");
		end

	// slot bookkeeping and reset state
	slot_bound: assert property (@(posedge i_clk) disable iff (!i_rst)
		i_slot_cnt <= OCC_BW'(N_SLOTS))
		else begin
			fail_count++;
			$error("slot occupancy above the number of slots");
		end

	idle_in_reset: assert property (@(posedge i_clk)
		!i_rst |-> !i_row_rdy && !i_ra_rdy && !i_req_ack)
		else begin
			fail_count++;
			$error("handshake output active during reset");
		end

endmodule

`default_nettype wire

//--- tile_read_trace.txt
# base rows stride tag addr0 addr1 addr2 addr3 (all hex)
# addresses past the row count are 0000 and unused
0100 4 0010 1 0100 0110 0120 0130
0200 1 0040 2 0200 0000 0000 0000
1000 3 0100 3 1000 1100 1200 0000
2345 2 0008 4 2345 234d 0000 0000
fff0 4 0008 5 fff0 fff8 0000 0008
0400 4 0000 6 0400 0400 0400 0400
0a00 2 0200 7 0a00 0c00 0000 0000
3000 4 1000 8 3000 4000 5000 6000
0042 1 0001 9 0042 0000 0000 0000
7ffc 3 0004 a 7ffc 8000 8004 0000
5555 4 0111 b 5555 5666 5777 5888
0800 2 0020 c 0800 0820 0000 0000
9000 4 0010 d 9000 9010 9020 9030
a000 3 0040 e a000 a040 a080 0000
b000 2 0100 f b000 b100 0000 0000
c000 4 0004 0 c000 c004 c008 c00c

//--- tile_read_types_pkg.sv
// payload types of the tile read pipeline
//   tile_req_t  tile request from the host side
//   slot_cmd_t  slot command between the pipeline stages
//   row_data_t  one buffer row, as returned by DRAM
//   row_out_t   tagged output row with last flag
`default_nettype none

package tile_read_types_pkg;

	import tile_read_cfg_pkg::*;

	// 39 bits
	typedef struct packed {
		logic [GADDR_BW-1:0]  base;
		logic [ROWCNT_BW-1:0] rows;
		logic [GADDR_BW-1:0]  stride;
		logic [TAG_BW-1:0]    tag;
	} tile_req_t;

	// 8 bits
	typedef struct packed {
		logic [SLOT_BW-1:0]   slot;
		logic [ROWCNT_BW-1:0] rows;
		logic [TAG_BW-1:0]    tag;
	} slot_cmd_t;

	// word 0 sits in the low bits
	typedef struct packed {
		logic [ROW_WORDS-1:0][WORD_BW-1:0] words;
	} row_data_t;

	// 133 bits
	typedef struct packed {
		row_data_t         row;
		logic [TAG_BW-1:0] tag;
		logic              last;
	} row_out_t;

endpackage

`default_nettype wire

//--- tile_reader.sv
// output side of the tile read pipeline
// walks the rows of a finished slot and streams them out tagged
// pulses slot free when the last row is taken
`default_nettype none

module tile_reader
	import tile_read_cfg_pkg::*;
	import tile_read_types_pkg::*;
(
	input  wire logic         i_clk,
	input  wire logic         i_rst,
	input  wire logic         i_cmd_rdy,
	output logic              o_cmd_ack,
	input  wire slot_cmd_t    i_cmd,
	output logic              o_rd_en,
	output logic [BUF_AW-1:0] o_rd_addr,
	input  wire row_data_t    i_rd_row,
	output logic              o_row_rdy,
	input  wire logic         i_row_ack,
	output row_out_t          o_row,
	output logic              o_slot_free
);

	slot_cmd_t             cmd_q;
	logic                  active;
	logic [ROW_IDX_BW-1:0] row_idx;
	logic                  pop;
	logic                  row_xfer;
	logic                  last_row;

	assign o_cmd_ack = i_cmd_rdy && !active;
	assign pop       = i_cmd_rdy && o_cmd_ack;
	assign row_xfer  = o_row_rdy && i_row_ack;
	assign last_row  = (ROWCNT_BW'(row_idx) + ROWCNT_BW'(1)) == cmd_q.rows;

	// ==================================================
	// buffer reads
	// ==================================================
	// row 0 is read in the pop cycle, the next row on each transfer
	assign o_rd_en   = pop || (row_xfer && !last_row);
	assign o_rd_addr = pop ? {i_cmd.slot, ROW_IDX_BW'(0)} : {cmd_q.slot, row_idx + 1'b1};

	// buffer output is stable until the next read
	assign o_row_rdy   = active;
	assign o_row.row   = i_rd_row;
	assign o_row.tag   = cmd_q.tag;
	assign o_row.last  = last_row;
	assign o_slot_free = row_xfer && last_row;

	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			active  <= 1'b0;
			row_idx <= '0;
		end else if (pop) begin
			active  <= 1'b1;
			row_idx <= '0;
		end else if (row_xfer) begin
			if (last_row) begin
				active <= 1'b0;
			end else begin
				row_idx <= row_idx + 1'b1;
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (pop) begin
			cmd_q <= i_cmd;
		end
	end

endmodule

`default_nettype wire
